//--- rs_div_config.svh
`ifndef RS_DIV_CONFIG_SVH
`define RS_DIV_CONFIG_SVH

// station geometry
`define RS_DEPTH   16
`define RS_IDX_W   4
`define RS_WINDOW  8   // slots searched from head

// field widths
`define PC_W       32
`define TAG_W      8   // physical register tag
`define OP_W       4

// result broadcast ports: alu, mul, div, load
`define NUM_WAKEUP 4

`endif

//--- rs_div_pkg.sv
`default_nettype none

`include "rs_div_config.svh"

package rs_div_pkg;

    // instruction as it arrives from dispatch
    typedef struct packed {
        logic [`PC_W-1:0]  pc;
        logic [`TAG_W-1:0] dest;
        logic [`OP_W-1:0]  op;
        logic [`TAG_W-1:0] src1;
        logic [`TAG_W-1:0] src2;
        logic              rdy1;  // src1 already available
        logic              rdy2;
    } rs_dispatch_t;

    // one result broadcast port
    typedef struct packed {
        logic              valid;
        logic [`TAG_W-1:0] tag;
    } rs_wakeup_t;

    // packet handed to the divide unit
    typedef struct packed {
        logic [`PC_W-1:0]  pc;
        logic [`TAG_W-1:0] dest;
        logic [`OP_W-1:0]  op;
        logic [`TAG_W-1:0] src1;
        logic [`TAG_W-1:0] src2;
    } rs_issue_t;

endpackage

`default_nettype wire

//--- rs_alloc_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_div_config.svh"

module rs_alloc_ctrl (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,
    input  logic                 dispatch_req,
    input  logic [`RS_DEPTH-1:0] occupied,
    output logic                 dispatch_ack,
    output logic                 wr_en,
    output logic [`RS_IDX_W-1:0] tail
);

    logic full;

    assign full = occupied[tail];  // slot at tail still held

    // new request, not yet acknowledged, room available
    assign wr_en = dispatch_req & ~dispatch_ack & ~full;

    // four-phase handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dispatch_ack <= 1'b0;
        end else if (wr_en) begin
            dispatch_ack <= 1'b1;
        end else if (!dispatch_req) begin
            dispatch_ack <= 1'b0;  // req seen low
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail <= '0;
        end else if (flush) begin
            tail <= '0;
        end else if (wr_en) begin
            tail <= tail + `RS_IDX_W'(1);  // wraps with depth
        end
    end

endmodule

`default_nettype wire

//--- rs_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_div_config.svh"

module rs_entry_array (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     flush,
    input  logic                                     wr_en,
    input  logic [`RS_IDX_W-1:0]                     tail,
    input  rs_div_pkg::rs_dispatch_t                 dispatch,
    input  rs_div_pkg::rs_wakeup_t [`NUM_WAKEUP-1:0] wakeup,
    input  logic                                     grant,
    input  logic [`RS_IDX_W-1:0]                     grant_idx,
    output logic [`RS_DEPTH-1:0]                     occupied,
    output logic [`RS_DEPTH-1:0]                     ready,
    output rs_div_pkg::rs_issue_t                    grant_pkt
);

    import rs_div_pkg::*;

    rs_issue_t            slot_q [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] occ_q;
    logic [`RS_DEPTH-1:0] rdy1_q;
    logic [`RS_DEPTH-1:0] rdy2_q;
    logic [`RS_DEPTH-1:0] wake1;
    logic [`RS_DEPTH-1:0] wake2;
    logic                 disp_wake1;
    logic                 disp_wake2;

    // any valid broadcast carrying this tag
    function automatic logic tag_hit(input logic [`TAG_W-1:0] tag,
                                     input rs_wakeup_t [`NUM_WAKEUP-1:0] wk);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `NUM_WAKEUP; p++) begin
            hit |= wk[p].valid && (wk[p].tag == tag);
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            wake1[i] = occ_q[i] & ~rdy1_q[i] & tag_hit(slot_q[i].src1, wakeup);
            wake2[i] = occ_q[i] & ~rdy2_q[i] & tag_hit(slot_q[i].src2, wakeup);
        end
    end

    // same-cycle bypass for the entry being written
    assign disp_wake1 = tag_hit(dispatch.src1, wakeup);
    assign disp_wake2 = tag_hit(dispatch.src2, wakeup);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occ_q  <= '0;
            rdy1_q <= '0;
            rdy2_q <= '0;
        end else if (flush) begin
            occ_q  <= '0;
            rdy1_q <= '0;
            rdy2_q <= '0;
        end else begin
            rdy1_q <= rdy1_q | wake1;
            rdy2_q <= rdy2_q | wake2;
            if (grant) begin  // slot leaves on issue
                occ_q[grant_idx]  <= 1'b0;
                rdy1_q[grant_idx] <= 1'b0;
                rdy2_q[grant_idx] <= 1'b0;
            end
            if (wr_en) begin
                occ_q[tail]  <= 1'b1;
                rdy1_q[tail] <= dispatch.rdy1 | disp_wake1;
                rdy2_q[tail] <= dispatch.rdy2 | disp_wake2;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            slot_q[tail] <= '{pc:   dispatch.pc,
                              dest: dispatch.dest,
                              op:   dispatch.op,
                              src1: dispatch.src1,
                              src2: dispatch.src2};
        end
    end

    assign occupied  = occ_q;
    assign ready     = rdy1_q & rdy2_q;
    assign grant_pkt = slot_q[grant_idx];

endmodule

`default_nettype wire

//--- rs_issue_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_div_config.svh"

module rs_issue_select (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic [`RS_DEPTH-1:0]  occupied,
    input  logic [`RS_DEPTH-1:0]  ready,
    input  logic [`RS_IDX_W-1:0]  tail,
    input  rs_div_pkg::rs_issue_t grant_pkt,
    output logic                  grant,
    output logic [`RS_IDX_W-1:0]  grant_idx,
    output logic                  issue_valid,
    output rs_div_pkg::rs_issue_t issue
);

    logic [`RS_IDX_W-1:0] head;
    logic [`RS_DEPTH-1:0] eligible;
    logic                 head_adv;

    assign eligible = occupied & ready;

    // oldest eligible slot in the window from head
    always_comb begin
        logic [`RS_IDX_W-1:0] idx;
        grant     = 1'b0;
        grant_idx = head;
        for (int i = 0; i < `RS_WINDOW; i++) begin
            idx = head + `RS_IDX_W'(i);  // wraps around depth
            if (!grant && eligible[idx]) begin
                grant     = 1'b1;
                grant_idx = idx;
            end
        end
    end

    // skip freed slots up to tail
    assign head_adv = ~occupied[head] & (head != tail);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
        end else if (flush) begin
            head <= '0;
        end else if (head_adv) begin
            head <= head + `RS_IDX_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= grant & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            issue <= grant_pkt;  // held until next grant
        end
    end

endmodule

`default_nettype wire

//--- rs_div_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_div_config.svh"

module rs_div_top (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     flush,
    input  logic                                     dispatch_req,
    input  rs_div_pkg::rs_dispatch_t                 dispatch,
    output logic                                     dispatch_ack,
    input  rs_div_pkg::rs_wakeup_t [`NUM_WAKEUP-1:0] wakeup,
    output logic                                     issue_valid,
    output rs_div_pkg::rs_issue_t                    issue
);

    import rs_div_pkg::*;

    logic                 wr_en;
    logic [`RS_IDX_W-1:0] tail;
    logic [`RS_DEPTH-1:0] occupied;
    logic [`RS_DEPTH-1:0] ready;
    logic                 grant;
    logic [`RS_IDX_W-1:0] grant_idx;
    rs_issue_t            grant_pkt;

    rs_alloc_ctrl u_alloc (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .dispatch_req (dispatch_req),
        .occupied     (occupied),
        .dispatch_ack (dispatch_ack),
        .wr_en        (wr_en),
        .tail         (tail)
    );

    rs_entry_array u_entries (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .wr_en     (wr_en),
        .tail      (tail),
        .dispatch  (dispatch),
        .wakeup    (wakeup),
        .grant     (grant),
        .grant_idx (grant_idx),
        .occupied  (occupied),
        .ready     (ready),
        .grant_pkt (grant_pkt)
    );

    rs_issue_select u_select (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush       (flush),
        .occupied    (occupied),
        .ready       (ready),
        .tail        (tail),
        .grant_pkt   (grant_pkt),
        .grant       (grant),
        .grant_idx   (grant_idx),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

endmodule

`default_nettype wire

//--- tb_rs_div.sv
`timescale 1ns/1ps
`default_nettype none

`include "rs_div_config.svh"

module tb_rs_div;

    import rs_div_pkg::*;

    logic                               clk;
    logic                               arst_n;
    logic                               flush;
    logic                               req;
    rs_dispatch_t                       disp;
    logic                               dispatch_ack;
    rs_wakeup_t [`NUM_WAKEUP-1:0]       wk;
    logic                               issue_valid;
    rs_issue_t                          issue;

    // reference model state
    rs_issue_t            m_slot [`RS_DEPTH];
    logic [`RS_DEPTH-1:0] m_occ;
    logic [`RS_DEPTH-1:0] m_r1;
    logic [`RS_DEPTH-1:0] m_r2;
    logic [`RS_IDX_W-1:0] m_head;
    logic [`RS_IDX_W-1:0] m_tail;
    logic                 m_ack;
    logic                 m_valid;
    rs_issue_t            m_pkt;
    rs_issue_t            pred_q [$];  // predicted issues awaiting a case line

    int cycles = 0;
    int limit = 0;

    rs_div_top dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .dispatch_req (req),
        .dispatch     (disp),
        .dispatch_ack (dispatch_ack),
        .wakeup       (wk),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    function automatic logic bcast_hit(input logic [`TAG_W-1:0] t);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `NUM_WAKEUP; p++) begin
            if (wk[p].valid && wk[p].tag == t) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic model_step();
        logic                 wr;
        logic                 found;
        logic                 adv;
        logic [`RS_IDX_W-1:0] sel;
        logic [`RS_IDX_W-1:0] idx;
        wr    = req & ~m_ack & ~m_occ[m_tail];
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < `RS_WINDOW; i++) begin
            idx = m_head + `RS_IDX_W'(i);
            if (!found && m_occ[idx] && m_r1[idx] && m_r2[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
        adv     = !m_occ[m_head] && (m_head != m_tail);
        m_valid = found && !flush;
        if (found) begin
            m_pkt = m_slot[sel];
            if (!flush) pred_q.push_back(m_slot[sel]);
        end
        if (wr) m_ack = 1'b1;
        else if (!req) m_ack = 1'b0;
        if (flush) begin  // handshake state survives the flush
            m_occ  = '0;
            m_r1   = '0;
            m_r2   = '0;
            m_head = '0;
            m_tail = '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (m_occ[i] && !m_r1[i] && bcast_hit(m_slot[i].src1)) m_r1[i] = 1'b1;
                if (m_occ[i] && !m_r2[i] && bcast_hit(m_slot[i].src2)) m_r2[i] = 1'b1;
            end
            if (found) begin
                m_occ[sel] = 1'b0;
                m_r1[sel]  = 1'b0;
                m_r2[sel]  = 1'b0;
            end
            if (wr) begin
                m_slot[m_tail] = '{pc: disp.pc, dest: disp.dest, op: disp.op,
                                   src1: disp.src1, src2: disp.src2};
                m_occ[m_tail]  = 1'b1;
                m_r1[m_tail]   = disp.rdy1 | bcast_hit(disp.src1);
                m_r2[m_tail]   = disp.rdy2 | bcast_hit(disp.src2);
                m_tail         = m_tail + `RS_IDX_W'(1);
            end
            if (adv) m_head = m_head + `RS_IDX_W'(1);
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            m_occ   = '0;
            m_r1    = '0;
            m_r2    = '0;
            m_head  = '0;
            m_tail  = '0;
            m_ack   = 1'b0;
            m_valid = 1'b0;
            m_pkt   = '0;
        end else begin
            model_step();
        end
    end

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("FAILED at time %0t: %s", $time, msg);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // compare outputs at the falling edge and finish the handshake
    task automatic step();
        @(negedge clk);
        check(issue_valid === m_valid, "issue_valid differs from model");
        if (m_valid) check(issue === m_pkt, "issue packet differs from model");
        check(dispatch_ack === m_ack, "dispatch_ack differs from model");
        if (req && dispatch_ack) req = 1'b0;
    endtask

    task automatic do_dispatch(input logic [31:0] pc, input logic [31:0] dest,
                               input logic [31:0] op, input logic [31:0] s1,
                               input logic [31:0] s2, input logic [31:0] r1,
                               input logic [31:0] r2);
        while (req || dispatch_ack) step();  // previous handshake must be idle
        disp.pc   = pc;
        disp.dest = dest[`TAG_W-1:0];
        disp.op   = op[`OP_W-1:0];
        disp.src1 = s1[`TAG_W-1:0];
        disp.src2 = s2[`TAG_W-1:0];
        disp.rdy1 = r1[0];
        disp.rdy2 = r2[0];
        req       = 1'b1;
    endtask

    task automatic expect_issue(input rs_issue_t exp);
        rs_issue_t got;
        while (pred_q.size() == 0) step();
        got = pred_q.pop_front();
        check(got === exp, "model issue order differs from expected case line");
    endtask

    initial begin
        int          fd;
        int          code;
        int          n_rec;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a, b, c, d, e, f, g;
        arst_n = 1'b0;
        flush  = 1'b0;
        req    = 1'b0;
        disp   = '0;
        wk     = '0;
        fd = $fopen("rs_div_cases.txt", "r");
        check(fd != 0, "cannot open rs_div_cases.txt");
        n_rec = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line[0] != "#" && line[0] != "\n") n_rec++;
        end
        $fclose(fd);
        limit = 40 * n_rec + 16;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        step();
        check(!issue_valid && !dispatch_ack, "outputs not low after reset");
        fd = $fopen("rs_div_cases.txt", "r");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line[0] != "#" && line[0] != "\n") begin
                code = $sscanf(line, "%c %h %h %h %h %h %h %h", kind, a, b, c, d, e, f, g);
                if (kind == "D") begin
                    do_dispatch(a, b, c, d, e, f, g);
                end else if (kind == "B") begin  // burst of entries waiting on src1
                    for (int i = 0; i < int'(a); i++) begin
                        do_dispatch(b + 32'(4 * i), c + 32'(i), 32'd7, d + 32'(i), 0, 0, 1);
                    end
                end else if (kind == "W") begin
                    wk[a[1:0]].valid = 1'b1;
                    wk[a[1:0]].tag   = b[`TAG_W-1:0];
                    step();
                    wk = '0;
                end else if (kind == "F") begin
                    flush = 1'b1;
                    step();
                    flush = 1'b0;
                end else if (kind == "I") begin
                    repeat (a) step();
                end else if (kind == "E") begin
                    expect_issue(rs_issue_t'{pc: a, dest: b[`TAG_W-1:0], op: c[`OP_W-1:0],
                                             src1: d[`TAG_W-1:0], src2: e[`TAG_W-1:0]});
                end else begin
                    check(1'b0, "unknown record kind in rs_div_cases.txt");
                end
            end
        end
        $fclose(fd);
        repeat (8) step();
        check(pred_q.size() == 0, "issue seen that no case line expects");
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rs_div_cases.txt
# D pc dest op src1 src2 rdy1 rdy2 | B count pc dest tag | W port tag | F | I cycles
# E pc dest op src1 src2 = expected issue, in order (all fields hex)
D 00001000 21 1 05 06 1 1
E 00001000 21 1 05 06
D 00001004 22 2 10 11 0 1
D 00001008 23 3 12 13 1 0
W 2 13
E 00001008 23 3 12 13
W 0 10
E 00001004 22 2 10 11
D 0000100c 24 4 14 01 0 1
D 00001010 25 5 14 14 0 0
W 1 14
E 0000100c 24 4 14 01
E 00001010 25 5 14 14
D 00002000 31 1 30 02 0 1
W 0 30
D 00002004 32 1 31 02 0 1
W 1 31
D 00002008 33 1 32 02 0 1
W 2 32
D 0000200c 34 1 33 02 0 1
W 3 33
E 00002000 31 1 30 02
E 00002004 32 1 31 02
E 00002008 33 1 32 02
E 0000200c 34 1 33 02
B 10 00003000 50 40
D 00003100 5f 3 03 04 1 1
I 5
W 0 40
E 00003000 50 7 40 00
E 00003100 5f 3 03 04
F
B 8 00004000 70 60
D 00004100 7a 2 01 02 1 1
I 6
W 0 60
E 00004000 70 7 60 00
E 00004100 7a 2 01 02
F
W 0 61
W 1 62
I 4
D 00005000 7f 6 05 06 1 1
E 00005000 7f 6 05 06
I 6

//--- list.f
+incdir+.
rs_div_pkg.sv
rs_alloc_ctrl.sv
rs_entry_array.sv
rs_issue_select.sv
rs_div_top.sv
tb_rs_div.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the reservation station testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_rs_div -o tb_rs_div

./obj_dir/tb_rs_div
